//--- files.f
+incdir+source
source/egress_types_pkg.sv
source/egress_regs_pkg.sv
source/egress_demux.sv
source/port_downsizer.sv
source/egress_status_regs.sv
source/egress_router.sv
test/egress_router_tb.sv

//--- Makefile
TOP     = tb_egress_router
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR) -f files.f

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/egress_router_tb.sv
////////////////////////////////////////////////////////////
// Egress router testbench with packet stimulus, reference
// model, output comparison and APB counter checks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "egress_params.svh"

module tb_egress_router
    import egress_types_pkg::*;
    import egress_regs_pkg::*;
();

    localparam int NUM_PKTS       = 60;
    localparam int TIMEOUT_CYCLES = 60000;

    // One expected chunk on the 32-bit port
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
    } chunk32_t;

    logic                          clk_ifc;
    logic                          rst_n;
    egr_beat_t                     egr_in;
    logic                          egr_valid;
    logic                          egr_ready;
    logic [`NUM_8B_PORTS-1:0][7:0] port8_data;
    logic [`NUM_8B_PORTS-1:0]      port8_last;
    logic [`NUM_8B_PORTS-1:0]      port8_valid;
    logic [`NUM_8B_PORTS-1:0]      port8_ready = '0;
    logic [31:0]                   port32_data;
    logic [3:0]                    port32_keep;
    logic                          port32_last;
    logic                          port32_valid;
    logic                          port32_ready = 1'b0;
    apb_req_t                      apb_req;
    apb_rsp_t                      apb_rsp;

    integer     seed = 23;
    int         pkt_dest [NUM_PKTS];
    int         pkt_len [NUM_PKTS];
    logic [8:0] exp_byte0 [$];
    logic [8:0] exp_byte1 [$];
    chunk32_t   exp_chunk32 [$];
    // Index 3 holds the drop count
    int         exp_cnt [`NUM_PORTS+1];
    logic       saw_stall;

    initial clk_ifc = 1'b0;
    always #50 clk_ifc = ~clk_ifc;

    egress_router uut (.*);

    ////////////////////////////////////////////////////////////
    // Reference model and checks

    // Bytes of packet n count up from n and entries carry {last, byte}
    function automatic void build_reference();
        chunk32_t   c;
        logic [7:0] b;
        c = '0;
        for (int p = 0; p <= `NUM_PORTS; p++) begin
            exp_cnt[p] = 0;
        end
        for (int n = 0; n < NUM_PKTS; n++) begin
            exp_cnt[pkt_dest[n]]++;
            for (int k = 0; k < pkt_len[n]; k++) begin
                b = 8'(n + k);
                case (pkt_dest[n])
                    0: exp_byte0.push_back({k == pkt_len[n] - 1, b});
                    1: exp_byte1.push_back({k == pkt_len[n] - 1, b});
                    2: begin
                        if (k % 4 == 0) begin
                            c = '0;
                        end
                        c.data[(k % 4) * 8 +: 8] = b;
                        c.keep[k % 4]            = 1'b1;
                        if (k % 4 == 3 || k == pkt_len[n] - 1) begin
                            c.last = k == pkt_len[n] - 1;
                            exp_chunk32.push_back(c);
                        end
                    end
                    default: ;
                endcase
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_byte(input int p, input logic [8:0] e);
        check_value($sformatf("port %0d data", p), 64'(port8_data[p]), 64'(e[7:0]));
        check_value($sformatf("port %0d last", p), 64'(port8_last[p]), 64'(e[8]));
    endtask

    // Bytes outside keep are don't care
    task automatic check_chunk(input chunk32_t e);
        logic [31:0] mask;
        for (int j = 0; j < 4; j++) begin
            mask[j * 8 +: 8] = {8{e.keep[j]}};
        end
        check_value("port 2 keep", 64'(port32_keep), 64'(e.keep));
        check_value("port 2 last", 64'(port32_last), 64'(e.last));
        check_value("port 2 data", 64'(port32_data & mask), 64'(e.data & mask));
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus

    task automatic send_packet(input int n);
        egr_beat_t beat;
        for (int k = 0; k < pkt_len[n]; k += `EGR_DATA_BYTES) begin
            beat      = '0;
            beat.port = port_idx_t'(pkt_dest[n]);
            for (int j = 0; j < `EGR_DATA_BYTES && k + j < pkt_len[n]; j++) begin
                beat.data[j * 8 +: 8] = 8'(n + k + j);
                beat.keep[j]          = 1'b1;
            end
            beat.last = k + `EGR_DATA_BYTES >= pkt_len[n];
            egr_in    <= beat;
            egr_valid <= 1'b1;
            @(posedge clk_ifc);
            while (!egr_ready) begin
                @(posedge clk_ifc);
            end
        end
    endtask

    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              output logic [31:0] rdata, output logic slverr);
        apb_req_t req;
        req       = '0;
        req.sel   = 1'b1;
        req.write = is_write;
        req.addr  = addr;
        apb_req  <= req;
        @(posedge clk_ifc);
        req.enable = 1'b1;
        apb_req   <= req;
        @(posedge clk_ifc);
        while (!apb_rsp.ready) begin
            @(posedge clk_ifc);
        end
        rdata    = apb_rsp.rdata;
        slverr   = apb_rsp.slverr;
        apb_req <= '0;
    endtask

    // Random back-pressure on every output
    always @(posedge clk_ifc) begin
        if (!rst_n) begin
            port8_ready  <= '0;
            port32_ready <= 1'b0;
        end else begin
            port8_ready  <= 2'($random(seed));
            port32_ready <= 1'($random(seed));
        end
    end

    always @(posedge clk_ifc) begin
        if (!rst_n) begin
            saw_stall <= 1'b0;
        end else if (egr_valid && !egr_ready) begin
            saw_stall <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitors

    always @(posedge clk_ifc) begin
        if (rst_n && port8_valid[0] && port8_ready[0]) begin
            if (exp_byte0.size() == 0) begin
                fail_now("port 0 sent a byte that was never addressed to it");
            end else begin
                check_byte(0, exp_byte0.pop_front());
            end
        end
        if (rst_n && port8_valid[1] && port8_ready[1]) begin
            if (exp_byte1.size() == 0) begin
                fail_now("port 1 sent a byte that was never addressed to it");
            end else begin
                check_byte(1, exp_byte1.pop_front());
            end
        end
        if (rst_n && port32_valid && port32_ready) begin
            if (exp_chunk32.size() == 0) begin
                fail_now("port 2 sent a chunk that was never addressed to it");
            end else begin
                check_chunk(exp_chunk32.pop_front());
            end
        end
    end

    // Worst case 60 packets of 200 single-byte chunks at half rate plus margin
    initial begin
        for (int cycle_cnt = 0; cycle_cnt < TIMEOUT_CYCLES; cycle_cnt++) begin
            @(posedge clk_ifc);
        end
        $display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        rst_n     <= 1'b0;
        egr_in    <= '0;
        egr_valid <= 1'b0;
        apb_req   <= '0;
        for (int n = 0; n < NUM_PKTS; n++) begin
            pkt_dest[n] = $unsigned($random(seed)) % 4;
            pkt_len[n]  = $unsigned($random(seed)) % 200 + 1;
        end
        build_reference();
        repeat (10) @(posedge clk_ifc);
        check_value("port8_valid in reset", 64'(port8_valid), 64'd0);
        check_value("port32_valid in reset", 64'(port32_valid), 64'd0);
        check_value("APB ready in reset", 64'(apb_rsp.ready), 64'd0);
        rst_n <= 1'b1;
        @(posedge clk_ifc);
        for (int n = 0; n < NUM_PKTS; n++) begin
            send_packet(n);
        end
        egr_valid <= 1'b0;
        while (exp_byte0.size() + exp_byte1.size() + exp_chunk32.size() != 0) begin
            @(posedge clk_ifc);
        end
        repeat (4) @(posedge clk_ifc);
        check_value("input stall seen", 64'(saw_stall), 64'd1);

        // Counters once the stream is idle
        for (int p = 0; p < `NUM_PORTS; p++) begin
            apb_access(1'b0, 8'(4 * p), rdata, slverr);
            check_value($sformatf("PKT_CNT_%0d", p), 64'(rdata), 64'(exp_cnt[p]));
        end
        apb_access(1'b0, DROP_CNT, rdata, slverr);
        check_value("DROP_CNT", 64'(rdata), 64'(exp_cnt[3]));
        check_value("DROP_CNT slverr", 64'(slverr), 64'd0);
        apb_access(1'b1, PKT_CNT_1, rdata, slverr);
        apb_access(1'b0, PKT_CNT_1, rdata, slverr);
        check_value("PKT_CNT_1 after clear", 64'(rdata), 64'd0);
        apb_access(1'b0, 8'h10, rdata, slverr);
        check_value("slverr at 0x10", 64'(slverr), 64'd1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- source/egress_router.sv
////////////////////////////////////////////////////////////
// Egress router top with demux, port downsizers and status block
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "egress_params.svh"

module egress_router
    import egress_types_pkg::*;
    import egress_regs_pkg::*;
(
    input  logic                               clk_ifc,
    input  logic                               rst_n,

    input  egr_beat_t                          egr_in,
    input  logic                               egr_valid,
    output logic                               egr_ready,

    output logic [`NUM_8B_PORTS-1:0][7:0]      port8_data,
    output logic [`NUM_8B_PORTS-1:0]           port8_last,
    output logic [`NUM_8B_PORTS-1:0]           port8_valid,
    input  logic [`NUM_8B_PORTS-1:0]           port8_ready,

    output logic [31:0]                        port32_data,
    output logic [3:0]                         port32_keep,
    output logic                               port32_last,
    output logic                               port32_valid,
    input  logic                               port32_ready,

    input  apb_req_t                           apb_req,
    output apb_rsp_t                           apb_rsp
);

    port_word_t            port_word;
    logic [`NUM_PORTS-1:0] port_valid;
    logic [`NUM_PORTS-1:0] port_ready;
    logic [`NUM_PORTS-1:0] pkt_done;
    logic                  drop_evt;

    egress_demux u_demux (
        .clk_ifc    ( clk_ifc    ),
        .rst_n      ( rst_n      ),
        .egr_in     ( egr_in     ),
        .egr_valid  ( egr_valid  ),
        .egr_ready  ( egr_ready  ),
        .port_word  ( port_word  ),
        .port_valid ( port_valid ),
        .port_ready ( port_ready ),
        .drop_evt   ( drop_evt   )
    );

    ////////////////////////////////////////////////////////////
    // Port downsizers with the narrow ports on the low indices

    for (genvar i = 0; i < `NUM_8B_PORTS; i++) begin : g_port8
        port_downsizer #(
            .OUT_BYTES ( 1 )
        ) u_ds8 (
            .clk_ifc   ( clk_ifc        ),
            .rst_n     ( rst_n          ),
            .in_word   ( port_word      ),
            .in_valid  ( port_valid[i]  ),
            .in_ready  ( port_ready[i]  ),
            .out_data  ( port8_data[i]  ),
            .out_keep  (                ),
            .out_last  ( port8_last[i]  ),
            .out_valid ( port8_valid[i] ),
            .out_ready ( port8_ready[i] ),
            .pkt_done  ( pkt_done[i]    )
        );
    end

    port_downsizer #(
        .OUT_BYTES ( 4 )
    ) u_ds32 (
        .clk_ifc   ( clk_ifc                   ),
        .rst_n     ( rst_n                     ),
        .in_word   ( port_word                 ),
        .in_valid  ( port_valid[`NUM_8B_PORTS] ),
        .in_ready  ( port_ready[`NUM_8B_PORTS] ),
        .out_data  ( port32_data               ),
        .out_keep  ( port32_keep               ),
        .out_last  ( port32_last               ),
        .out_valid ( port32_valid              ),
        .out_ready ( port32_ready              ),
        .pkt_done  ( pkt_done[`NUM_8B_PORTS]   )
    );

    egress_status_regs u_status (
        .clk_ifc  ( clk_ifc  ),
        .rst_n    ( rst_n    ),
        .pkt_done ( pkt_done ),
        .drop_evt ( drop_evt ),
        .apb_req  ( apb_req  ),
        .apb_rsp  ( apb_rsp  )
    );

endmodule

//--- source/egress_status_regs.sv
////////////////////////////////////////////////////////////
// APB status block with packet and drop counters
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "egress_params.svh"

module egress_status_regs
    import egress_types_pkg::*;
    import egress_regs_pkg::*;
(
    input  logic                  clk_ifc,
    input  logic                  rst_n,

    input  logic [`NUM_PORTS-1:0] pkt_done,
    input  logic                  drop_evt,

    input  apb_req_t              apb_req,
    output apb_rsp_t              apb_rsp
);

    // Port counters first and the drop counter in the top slot
    localparam int NUM_CNT = `NUM_PORTS + 1;
    localparam int SEL_W   = $clog2(NUM_CNT);

    cnt_t               cnt_q [NUM_CNT];
    logic [NUM_CNT-1:0] evt;
    logic [NUM_CNT-1:0] clr;
    logic [SEL_W-1:0]   sel_idx;
    logic               addr_hit;
    logic               access;

    assign evt    = {drop_evt, pkt_done};
    assign access = apb_req.sel && apb_req.enable;

    ////////////////////////////////////////////////////////////
    // Address decode

    always_comb begin
        addr_hit = 1'b1;
        sel_idx  = '0;
        case (apb_req.addr)
            PKT_CNT_0: sel_idx = SEL_W'(0);
            PKT_CNT_1: sel_idx = SEL_W'(1);
            PKT_CNT_2: sel_idx = SEL_W'(2);
            DROP_CNT:  sel_idx = SEL_W'(3);
            default:   addr_hit = 1'b0;
        endcase
    end

    always_comb begin
        clr = '0;
        if (access && apb_req.write && addr_hit) begin
            clr[sel_idx] = 1'b1;
        end
    end

    // Every access completes in its first enable cycle
    always_comb begin
        apb_rsp.ready  = access;
        apb_rsp.slverr = access && !addr_hit;
        apb_rsp.rdata  = '0;
        if (access && !apb_req.write && addr_hit) begin
            apb_rsp.rdata = 32'(cnt_q[sel_idx]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters

    // An event landing with a clear is kept as the first count
    always_ff @(posedge clk_ifc) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (!rst_n) begin
                cnt_q[i] <= '0;
            end else if (clr[i]) begin
                cnt_q[i] <= evt[i] ? cnt_t'(1) : '0;
            end else if (evt[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    a_enable_needs_sel: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        apb_req.enable |-> apb_req.sel
    ) else $error("egress_status_regs: enable without sel");

endmodule

//--- source/port_downsizer.sv
////////////////////////////////////////////////////////////
// Port word buffer with 64-bit to narrow width conversion
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "egress_params.svh"

module port_downsizer import egress_types_pkg::*; #(
    parameter int OUT_BYTES = 1
) (
    input  logic                   clk_ifc,
    input  logic                   rst_n,

    input  port_word_t             in_word,
    input  logic                   in_valid,
    output logic                   in_ready,

    output logic [OUT_BYTES*8-1:0] out_data,
    output logic [OUT_BYTES-1:0]   out_keep,
    output logic                   out_last,
    output logic                   out_valid,
    input  logic                   out_ready,

    output logic                   pkt_done
);

    localparam int DEPTH    = `PORT_FIFO_DEPTH;
    localparam int AW       = $clog2(DEPTH);
    localparam int OUT_BITS = OUT_BYTES * 8;
    localparam int NCHUNK   = `EGR_DATA_BYTES / OUT_BYTES;
    localparam int IDX_W    = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;

    port_word_t       mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    ds_state_e        state;
    logic [IDX_W-1:0] chunk_idx;
    port_word_t       head;
    egr_keep_t        keep_rest;
    logic             last_chunk;
    logic             push;
    logic             pop;
    logic             out_hs;

    assign in_ready = count != (AW+1)'(DEPTH);
    assign push     = in_valid && in_ready;

    ////////////////////////////////////////////////////////////
    // Circular buffer

    always_ff @(posedge clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Chunk emission

    // Head word is read straight from the buffer
    assign head = mem[rd_ptr];

    // Keep is contiguous, so no bits above this chunk means it is the final one
    assign keep_rest  = head.keep >> ((int'(chunk_idx) + 1) * OUT_BYTES);
    assign last_chunk = keep_rest == '0;

    assign out_valid = state == DS_EMIT;
    assign out_data  = head.data[chunk_idx*OUT_BITS +: OUT_BITS];
    assign out_keep  = head.keep[chunk_idx*OUT_BYTES +: OUT_BYTES];
    assign out_last  = head.last && last_chunk;
    assign out_hs    = out_valid && out_ready;
    assign pop       = out_hs && last_chunk;
    assign pkt_done  = out_hs && out_last;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state     <= DS_IDLE;
            chunk_idx <= '0;
        end else begin
            case (state)
                // Buffer is empty here until the next push
                DS_IDLE: begin
                    if (push) begin
                        state <= DS_EMIT;
                    end
                end
                DS_EMIT: begin
                    if (out_hs) begin
                        if (last_chunk) begin
                            chunk_idx <= '0;
                            if (count == (AW+1)'(1) && !push) begin
                                state <= DS_IDLE;
                            end
                        end else begin
                            chunk_idx <= chunk_idx + 1'b1;
                        end
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    // Pointers only meet on a push when the buffer is empty
    a_no_push_full: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        push |-> (wr_ptr != rd_ptr) || (state == DS_IDLE)
    ) else $error("port_downsizer: push into a full buffer");

    a_out_stable: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
                                    && $stable(out_keep) && $stable(out_last)
    ) else $error("port_downsizer: output changed while stalled");

endmodule

//--- source/egress_demux.sv
////////////////////////////////////////////////////////////
// Input stream steering to the per-port buffers
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "egress_params.svh"

module egress_demux import egress_types_pkg::*; (
    input  logic                  clk_ifc,
    input  logic                  rst_n,

    input  egr_beat_t             egr_in,
    input  logic                  egr_valid,
    output logic                  egr_ready,

    output port_word_t            port_word,
    output logic [`NUM_PORTS-1:0] port_valid,
    input  logic [`NUM_PORTS-1:0] port_ready,

    output logic                  drop_evt
);

    logic      port_exists;
    logic      egr_hs;
    logic      in_pkt;
    port_idx_t pkt_port;

    // Index 3 has no port behind it
    assign port_exists = egr_in.port < port_idx_t'(`NUM_PORTS);

    // Same word goes to every buffer and only the addressed one sees valid
    always_comb begin
        port_word.data = egr_in.data;
        port_word.keep = egr_in.keep;
        port_word.last = egr_in.last;
    end

    always_comb begin
        port_valid = '0;
        if (egr_valid && port_exists) begin
            port_valid[egr_in.port] = 1'b1;
        end
    end

    // Absent ports always accept so the packet drains away
    assign egr_ready = port_exists ? port_ready[egr_in.port] : 1'b1;
    assign egr_hs    = egr_valid && egr_ready;
    assign drop_evt  = egr_hs && !port_exists && egr_in.last;

    ////////////////////////////////////////////////////////////
    // Packet tracking

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (egr_hs) begin
            in_pkt <= !egr_in.last;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (egr_hs) begin
            pkt_port <= egr_in.port;
        end
    end

    // Destination must hold for a whole packet
    a_port_constant: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        egr_hs && in_pkt |-> egr_in.port == pkt_port
    ) else $error("egress_demux: port field changed inside a packet");

endmodule

//--- source/egress_regs_pkg.sv
////////////////////////////////////////////////////////////
// APB request/response structs and register map
////////////////////////////////////////////////////////////

`include "egress_params.svh"

package egress_regs_pkg;

    typedef struct packed {
        logic                   sel;
        logic                   enable;
        logic                   write;
        logic [`APB_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        slverr;
    } apb_rsp_t;

    typedef enum logic [`APB_ADDR_W-1:0] {
        PKT_CNT_0 = 8'h00,
        PKT_CNT_1 = 8'h04,
        PKT_CNT_2 = 8'h08,
        DROP_CNT  = 8'h0C
    } reg_addr_e;

endpackage

//--- source/egress_types_pkg.sv
////////////////////////////////////////////////////////////
// Stream, port index and counter types plus the downsizer
// state encoding
////////////////////////////////////////////////////////////

`include "egress_params.svh"

package egress_types_pkg;

    typedef logic [`EGR_DATA_BYTES*8-1:0] egr_data_t;
    typedef logic [`EGR_DATA_BYTES-1:0]   egr_keep_t;
    typedef logic [`PORT_IDX_W-1:0]       port_idx_t;
    typedef logic [`CNT_W-1:0]            cnt_t;

    // Beat on the input stream from the switching core
    typedef struct packed {
        egr_data_t data;
        egr_keep_t keep;
        logic      last;
        port_idx_t port;
    } egr_beat_t;

    // Word as held in a port buffer with the destination already resolved
    typedef struct packed {
        egr_data_t data;
        egr_keep_t keep;
        logic      last;
    } port_word_t;

    typedef enum logic {
        DS_IDLE,
        DS_EMIT
    } ds_state_e;

endpackage

//--- source/egress_params.svh
////////////////////////////////////////////////////////////
// Egress router sizing with port counts, widths, buffer
// depth and counter width
////////////////////////////////////////////////////////////

`ifndef EGRESS_PARAMS_SVH
`define EGRESS_PARAMS_SVH

// Input stream word size in bytes
`define EGR_DATA_BYTES 8

// Port arrays with the narrow ports on the low indices
`define NUM_8B_PORTS 2
`define NUM_32B_PORTS 1
`define NUM_PORTS 3
`define PORT_IDX_W 2

// Words held by each port buffer
`define PORT_FIFO_DEPTH 16

// Status block
`define CNT_W 16
`define APB_ADDR_W 8

`endif
